//--- bench/lke_cam_patterns.txt
# C test ctrl_word(hex) last fwd      control beat, fwd 1 means it must show on c_out
# L test key(hex) phv(hex) hit addr   lookup with expected hit flag and decimal address
# Test 2 header stage 2 lookup 2 index 5, entry ABC/12345 byte-reversed
C 2 00120000f2f10005 0 0
C 2 4523c1ab0badf00d 1 0
L 2 12345 112233445abc6677 1 5
# Test 3 unknown key, known key with another VLAN, key not yet written
L 3 12346 112233445abc6677 0 15
L 3 12345 112233445abd6677 0 15
L 3 00001 cafe0000f0010000 0 15
# Test 4 index 8, entries 001/00001, 7FE/ABCDE, then the same entry again
C 4 00120000f2f10008 0 0
C 4 0100100000000000 0 0
C 4 debcea7f00000000 0 0
C 4 debcea7f12345678 1 0
L 4 00001 cafe0000f0010000 1 8
L 4 abcde 0000000007fe1234 1 9
L 4 12345 112233445abc6677 1 5
# Test 5 wrong stage, wrong lookup, wrong flag, nonzero resv
C 5 001a0000f2f10003 1 1
C 5 00130000f2f10003 1 1
C 5 00120000f2f00003 0 1
C 5 4523c1ab0badf00d 1 1
C 5 03120000f2f10003 1 1
# Test 5 a real write to index 12 is consumed, entry 0F0/0ABCD
C 5 00120000f2f1000c 0 0
C 5 cdab000f55aa55aa 1 0
L 5 0abcd 0000111120f03333 1 12
# Test 6 every lookup is held off by ready_in for four cycles
L 6 12345 112233445abc6677 1 5
L 6 abcde 0000000007fe1234 1 9
L 6 0abcd 0000111120f03333 1 12
L 6 54321 ffffffff00000000 0 15

//--- files.f
source/lke_pkg.sv
source/cam_config_parser.sv
source/cam_table.sv
source/cam_lookup_stage.sv
source/lke_cam_top.sv
bench/lke_cam_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the CAM stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module lke_cam_tb -f files.f \
    && ./obj_dir/Vlke_cam_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation passed" sim.log && echo "PASS" && exit 0 || echo "FAIL" && exit 1

//--- bench/lke_cam_tb.sv
`timescale 1ns/1ps

module lke_cam_tb
    import lke_pkg::*;
();

    localparam int wait_limit = 40;

    logic                 clk;
    logic                 rst_n;
    logic                 key_valid;
    logic [key_width-1:0] extract_key;
    phv_t                 phv_in;
    logic                 ready_in;
    logic                 ready_out;
    phv_t                 phv_out;
    logic                 phv_out_valid;
    logic                 if_match;
    cam_addr_t            match_addr;
    logic                 c_in_valid;
    ctrl_word_t           c_in_data;
    logic                 c_in_last;
    logic                 c_out_valid;
    ctrl_word_t           c_out_data;
    logic                 c_out_last;

    logic [31:0] lcg_state;
    int          error_count;
    int          check_count;
    int          errors_at_test_start;
    int          current_test;
    int          lookups_sent;
    int          results_seen;
    int          forwards_expected;
    int          forwards_seen;
    bit          timed_out;

    lke_cam_top lke_cam_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Output strobes counted over the whole run
    always @(negedge clk) begin
        if (rst_n && phv_out_valid) results_seen++;
        if (rst_n && c_out_valid) forwards_seen++;
    end

    // ============================================================
    // Helpers
    // ============================================================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic string test_name(input int num);
        case (num)
            1: return "reset state";
            2: return "single write then hit";
            3: return "miss";
            4: return "multi-beat write and priority";
            5: return "bypass";
            6: return "back-pressure";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        check_count++;
        assert (got === exp) else begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
            error_count++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%0t %s", $time, msg);
        error_count++;
    endtask

    task automatic finish_test(input int num);
        int errs;
        errs = error_count - errors_at_test_start;
        if (errs == 0) begin
            $display("test %0d %s: ok", num, test_name(num));
        end else begin
            $display("test %0d %s: %0d errors", num, test_name(num), errs);
        end
        errors_at_test_start = error_count;
    endtask

    // Downstream is busy on roughly one cycle in four
    task automatic drive_ready();
        lcg_state = lcg_next(lcg_state);
        if (current_test == 5) ready_in = 1'b1;
        else ready_in = (lcg_state[17:16] != 2'b00);
    endtask

    // ============================================================
    // Drivers, entered 2 ns after a rising edge
    // ============================================================
    task automatic send_beat(input ctrl_word_t data, input logic last, input logic fwd);
        c_in_valid = 1'b1;
        c_in_data  = data;
        c_in_last  = last;
        @(posedge clk);
        #2;
        c_in_valid = 1'b0;
        check_value("c_out_valid", 64'(fwd), 64'(c_out_valid));
        if (fwd) begin
            forwards_expected++;
            check_value("c_out_data", data, c_out_data);
            check_value("c_out_last", 64'(last), 64'(c_out_last));
        end
    endtask

    task automatic await_result(input phv_t phv, input logic exp_hit,
                                input cam_addr_t exp_addr, input bit hold);
        int waited;
        bit got;
        waited = 0;
        got    = 1'b0;
        while (!got && waited < wait_limit) begin
            if (hold) ready_in = (waited >= 4);
            else drive_ready();
            #1;
            if (hold && waited < 4) check_value("ready_out", 64'd0, 64'(ready_out));
            @(posedge clk);
            #2;
            got = phv_out_valid;
            if (hold && waited < 4) check_value("phv_out_valid", 64'd0, 64'(phv_out_valid));
            if (hold && waited == 4 && !got) begin
                report_failure("no result in the cycle after ready_in returned");
            end
            waited++;
        end
        if (!got) begin
            report_failure("timeout waiting for phv_out_valid");
            timed_out = 1'b1;
        end else begin
            check_value("phv_out", phv, phv_out);
            check_value("if_match", 64'(exp_hit), 64'(if_match));
            check_value("match_addr", 64'(exp_addr), 64'(match_addr));
            check_value("ready_out", 64'd1, 64'(ready_out));
            // Exactly one result per key
            @(posedge clk);
            #2;
            check_value("phv_out_valid", 64'd0, 64'(phv_out_valid));
        end
    endtask

    task automatic run_lookup(input logic [key_width-1:0] key, input phv_t phv,
                              input logic exp_hit, input cam_addr_t exp_addr, input bit hold);
        int waited;
        key_valid   = 1'b1;
        extract_key = key;
        phv_in      = phv;
        drive_ready();
        #1;
        waited = 0;
        while (!ready_out && waited < wait_limit) begin
            @(posedge clk);
            #2;
            drive_ready();
            #1;
            waited++;
        end
        if (!ready_out) begin
            report_failure("timeout waiting for ready_out before a lookup");
            timed_out = 1'b1;
            key_valid = 1'b0;
        end else begin
            @(posedge clk);
            #2;
            lookups_sent++;
            // Inputs may wander once the key is taken
            key_valid   = 1'b0;
            lcg_state   = lcg_next(lcg_state);
            extract_key = lcg_state[key_width-1:0];
            phv_in      = {lcg_state, ~lcg_state};
            await_result(phv, exp_hit, exp_addr, hold);
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        int          fd;
        string       line;
        byte         op;
        int          n;
        int          t;
        int          a;
        int          b;
        logic [63:0] kval;
        logic [63:0] data;

        rst_n       = 1'b0;
        key_valid   = 1'b0;
        extract_key = '0;
        phv_in      = '0;
        ready_in    = 1'b1;
        c_in_valid  = 1'b0;
        c_in_data   = '0;
        c_in_last   = 1'b0;
        lcg_state   = 32'h2c1;
        error_count = 0;
        check_count = 0;
        errors_at_test_start = 0;
        lookups_sent      = 0;
        forwards_expected = 0;
        timed_out    = 1'b0;
        current_test = 1;
        t            = 1;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        check_value("phv_out_valid", 64'd0, 64'(phv_out_valid));
        check_value("if_match", 64'd0, 64'(if_match));
        check_value("c_out_valid", 64'd0, 64'(c_out_valid));
        check_value("match_addr", 64'd0, 64'(match_addr));
        check_value("ready_out", 64'd1, 64'(ready_out));

        fd = $fopen("bench/lke_cam_patterns.txt", "r");
        if (fd == 0) begin
            report_failure("could not open bench/lke_cam_patterns.txt");
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                op = (line.len() > 0) ? line.getc(0) : 8'd0;
                n  = 0;
                if (op == "C") n = $sscanf(line, "C %d %h %d %d", t, data, a, b);
                if (op == "L") n = $sscanf(line, "L %d %h %h %d %d", t, kval, data, a, b);
                if (op == "C" || op == "L") begin
                    if (t != current_test) begin
                        finish_test(current_test);
                        current_test = t;
                    end
                    if (op == "C" && n == 4) begin
                        send_beat(data, a != 0, b != 0);
                    end else if (op == "L" && n == 5) begin
                        run_lookup(kval[key_width-1:0], data, a != 0, cam_addr_t'(b), t == 6);
                    end else begin
                        report_failure("malformed line in the pattern file");
                    end
                end
            end
            $fclose(fd);
        end

        repeat (3) @(posedge clk);
        #2;
        check_value("result count", 64'(lookups_sent), 64'(results_seen));
        check_value("forwarded beats", 64'(forwards_expected), 64'(forwards_seen));
        finish_test(current_test);
        $display("tests %0d, lookups %0d, results %0d, checks %0d, errors %0d",
                 current_test, lookups_sent, results_seen, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- source/lke_cam_top.sv
`timescale 1ns/1ps

module lke_cam_top
    import lke_pkg::*;
#(
    parameter logic [4:0] stage_id  = 5'd2,
    parameter logic [2:0] lookup_id = 3'd2
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // Data path in
    input  logic                 key_valid,
    input  logic [key_width-1:0] extract_key,
    input  phv_t                 phv_in,
    output logic                 ready_out,

    // Data path out
    output phv_t                 phv_out,
    output logic                 phv_out_valid,
    output logic                 if_match,
    output cam_addr_t            match_addr,
    input  logic                 ready_in,

    // Control path
    input  logic                 c_in_valid,
    input  ctrl_word_t           c_in_data,
    input  logic                 c_in_last,
    output logic                 c_out_valid,
    output ctrl_word_t           c_out_data,
    output logic                 c_out_last
);

    // Parser to table
    logic       wr_en;
    cam_addr_t  wr_addr;
    cam_entry_t wr_data;

    // Lookup stage to table and back
    cam_entry_t cmp_word;
    logic       hit;
    cam_addr_t  hit_addr;

    // ============================================================
    // Control path
    // ============================================================
    cam_config_parser #(
        .stage_id  (stage_id),
        .lookup_id (lookup_id)
    ) cam_config_parser_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .c_in_valid  (c_in_valid),
        .c_in_data   (c_in_data),
        .c_in_last   (c_in_last),
        .c_out_valid (c_out_valid),
        .c_out_data  (c_out_data),
        .c_out_last  (c_out_last),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    cam_table cam_table_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .cmp_word (cmp_word),
        .hit      (hit),
        .hit_addr (hit_addr)
    );

    // ============================================================
    // Data path
    // ============================================================
    cam_lookup_stage cam_lookup_stage_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .key_valid     (key_valid),
        .extract_key   (extract_key),
        .phv_in        (phv_in),
        .ready_out     (ready_out),
        .ready_in      (ready_in),
        .cmp_word      (cmp_word),
        .hit           (hit),
        .hit_addr      (hit_addr),
        .phv_out       (phv_out),
        .phv_out_valid (phv_out_valid),
        .if_match      (if_match),
        .match_addr    (match_addr)
    );

endmodule

//--- source/cam_lookup_stage.sv
`timescale 1ns/1ps

module cam_lookup_stage
    import lke_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,

    // Key and PHV from the extractor
    input  logic                 key_valid,
    input  logic [key_width-1:0] extract_key,
    input  phv_t                 phv_in,
    output logic                 ready_out,

    // Downstream handshake
    input  logic                 ready_in,

    // CAM compare port
    output cam_entry_t           cmp_word,
    input  logic                 hit,
    input  cam_addr_t            hit_addr,

    // Result to the next stage
    output phv_t                 phv_out,
    output logic                 phv_out_valid,
    output logic                 if_match,
    output cam_addr_t            match_addr
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_halt
    } lookup_state_t;

    lookup_state_t state;

    phv_t phv_reg;
    logic accept;
    logic issue;

    // A new key may enter in the same cycle the held one leaves
    assign ready_out = (state == st_idle) || ((state == st_wait) && ready_in);
    assign accept    = key_valid && ready_out;
    assign issue     = (state != st_idle) && ready_in;

    // ============================================================
    // Key capture
    // ============================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            phv_reg  <= phv_in;
            cmp_word <= {phv_in[vlan_lsb +: vlan_width], extract_key};
        end
    end

    // ============================================================
    // Issue FSM
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_idle;
            phv_out       <= '0;
            phv_out_valid <= 1'b0;
            if_match      <= 1'b0;
            match_addr    <= '0;
        end else begin
            phv_out_valid <= 1'b0;

            // Table answer is taken at the issue edge
            if (issue) begin
                phv_out       <= phv_reg;
                phv_out_valid <= 1'b1;
                if_match      <= hit;
                match_addr    <= hit_addr;
            end

            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (!ready_in) begin
                        state <= st_halt;
                    end else if (!accept) begin
                        state <= st_idle;
                    end
                end
                st_halt: begin
                    if (ready_in) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- source/cam_table.sv
`timescale 1ns/1ps

module cam_table
    import lke_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // Write port from the config parser
    input  logic       wr_en,
    input  cam_addr_t  wr_addr,
    input  cam_entry_t wr_data,

    // Compare port
    input  cam_entry_t cmp_word,
    output logic       hit,
    output cam_addr_t  hit_addr
);

    cam_entry_t             entries [cam_depth];
    logic [cam_depth-1:0]   entry_valid;

    // ============================================================
    // Storage
    // ============================================================
    // Valid bits come up cleared so an empty table never matches
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (wr_en) begin
            entry_valid[wr_addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_addr] <= wr_data;
        end
    end

    // ============================================================
    // Parallel compare
    // ============================================================
    // Scan from the top down so the lowest matching address is left last
    always_comb begin
        hit      = 1'b0;
        hit_addr = miss_addr;
        for (int i = cam_depth - 1; i >= 0; i--) begin
            if (entry_valid[i] && (entries[i] == cmp_word)) begin
                hit      = 1'b1;
                hit_addr = cam_addr_t'(i);
            end
        end
    end

endmodule

//--- source/cam_config_parser.sv
`timescale 1ns/1ps

module cam_config_parser
    import lke_pkg::*;
#(
    parameter logic [4:0] stage_id  = 5'd2,
    parameter logic [2:0] lookup_id = 3'd2
) (
    input  logic       clk,
    input  logic       rst_n,

    // Control stream in
    input  logic       c_in_valid,
    input  ctrl_word_t c_in_data,
    input  logic       c_in_last,

    // Control stream out, bypass beats only
    output logic       c_out_valid,
    output ctrl_word_t c_out_data,
    output logic       c_out_last,

    // CAM write port
    output logic       wr_en,
    output cam_addr_t  wr_addr,
    output cam_entry_t wr_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_first_entry,
        st_next_entry
    } cfg_state_t;

    cfg_state_t state;

    logic [mod_id_width-1:0] mod_id;
    logic [resv_width-1:0]   resv;
    logic [flag_width-1:0]   control_flag;
    logic [index_width-1:0]  hdr_index;
    logic                    hdr_match;
    ctrl_word_t              swapped;

    // ============================================================
    // Header decode
    // ============================================================
    assign mod_id       = c_in_data[mod_id_lsb +: mod_id_width];
    assign resv         = c_in_data[resv_lsb +: resv_width];
    assign control_flag = c_in_data[flag_lsb +: flag_width];
    assign hdr_index    = c_in_data[index_lsb +: index_width];

    assign hdr_match = (mod_id == {stage_id, lookup_id})
                    && (control_flag == cam_cfg_flag)
                    && (resv == '0);

    // Little-endian to big-endian, whole word
    always_comb begin
        for (int b = 0; b < ctrl_width / 8; b++) begin
            swapped[8*b +: 8] = c_in_data[ctrl_width - 8 - 8*b +: 8];
        end
    end

    // ============================================================
    // Control FSM
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            c_out_valid <= 1'b0;
            c_out_data  <= '0;
            c_out_last  <= 1'b0;
            wr_en       <= 1'b0;
            wr_addr     <= '0;
            wr_data     <= '0;
        end else begin
            // Strobes drop unless set below
            wr_en       <= 1'b0;
            c_out_valid <= 1'b0;
            c_out_last  <= 1'b0;

            case (state)
                st_idle: begin
                    if (c_in_valid) begin
                        if (hdr_match) begin
                            // Header is consumed, index becomes the first write address
                            wr_addr <= hdr_index[addr_width-1:0];
                            if (!c_in_last) begin
                                state <= st_first_entry;
                            end
                        end else begin
                            c_out_valid <= 1'b1;
                            c_out_data  <= c_in_data;
                            c_out_last  <= c_in_last;
                        end
                    end
                end

                st_first_entry: begin
                    if (c_in_valid) begin
                        wr_en   <= 1'b1;
                        wr_data <= swapped[entry_width-1:0];
                        state   <= c_in_last ? st_idle : st_next_entry;
                    end
                end

                st_next_entry: begin
                    if (c_in_valid) begin
                        wr_en   <= 1'b1;
                        wr_data <= swapped[entry_width-1:0];
                        wr_addr <= wr_addr + 1'b1;
                        if (c_in_last) begin
                            state <= st_idle;
                        end
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- source/lke_pkg.sv
package lke_pkg;

    // ============================================================
    // Data path widths
    // ============================================================
    parameter int ctrl_width  = 64;
    parameter int phv_width   = 64;
    parameter int key_width   = 20;
    parameter int vlan_width  = 12;

    // VLAN id position inside the PHV
    parameter int vlan_lsb    = 16;

    // Entry layout is key in the low bits, VLAN above it
    parameter int entry_width = key_width + vlan_width;
    parameter int cam_depth   = 16;
    parameter int addr_width  = $clog2(cam_depth);

    // ============================================================
    // Control word header fields
    // ============================================================
    // mod_id is stage in the upper 5 bits, lookup in the lower 3
    parameter int mod_id_lsb   = 48;
    parameter int mod_id_width = 8;
    parameter int resv_lsb     = 56;
    parameter int resv_width   = 4;
    parameter int flag_lsb     = 16;
    parameter int flag_width   = 16;
    parameter int index_lsb    = 0;
    parameter int index_width  = 8;

    // Magic value marking a CAM configuration packet
    parameter logic [flag_width-1:0] cam_cfg_flag = 16'hf2f1;

    typedef logic [ctrl_width-1:0]  ctrl_word_t;
    typedef logic [phv_width-1:0]   phv_t;
    typedef logic [entry_width-1:0] cam_entry_t;
    typedef logic [addr_width-1:0]  cam_addr_t;

    // Address reported when nothing matches
    parameter cam_addr_t miss_addr = 4'd15;

endpackage
